// File: rtl/mem_gate_pkg.sv
package mem_gate_pkg;

	// one byte of UDP payload as delivered by the packet engine
	typedef logic [7:0] byte_t;

	// local bus address, the low 24 bits of a command word
	typedef logic [23:0] lb_addr_t;

	// local bus data word, also the width of every command word
	typedef logic [31:0] lb_data_t;

	// repeat counter loaded from the low bits of a repeat command
	typedef logic [8:0] rep_count_t;

	// control bits in the upper byte of a command word
	localparam int ctl_read_bit = 28;
	localparam int ctl_repeat_bit = 29;

	// leading bytes of every payload that are only echoed, never parsed
	localparam int pad_bytes = 8;

	// phase of the byte parser inside one packet
	typedef enum logic [1:0] {
		st_pad,
		st_cmd,
		st_data
	} parse_state_t;

endpackage

// File: rtl/reg_delay.sv
`timescale 1ns/1ps

// fixed delay line for a bus of dw bits, one register per cycle of latency
// a length of zero degenerates into a plain connection
module reg_delay
	import mem_gate_pkg::*;
#(
	parameter int len = 1,
	parameter int dw = $bits(byte_t)
) (
	input logic clk,
	input logic rst_n,
	input logic [dw-1:0] din,
	output logic [dw-1:0] dout
);

	generate
		if (len == 0) begin : g_wire
			assign dout = din;
		end else begin : g_pipe
			// stage 0 takes din, the last stage drives dout
			logic [dw-1:0] stage [len];

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int i = 0; i < len; i++) begin
						stage[i] <= '0;
					end
				end else begin
					stage[0] <= din;
					for (int i = 1; i < len; i++) begin
						stage[i] <= stage[i-1];
					end
				end
			end

			assign dout = stage[len-1];
		end
	endgenerate

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps

// small register target on the local bus
// it holds 2**bank_addr_bits words and accesses above that range are ignored on
// write and return zero on read
// read data comes out read_pipe_len cycles after the read strobe
module reg_bank
	import mem_gate_pkg::*;
#(
	parameter int read_pipe_len = 3,
	parameter int bank_addr_bits = 4
) (
	input logic clk,
	input logic rst_n,
	input lb_addr_t addr,
	input lb_data_t data_out,
	input logic control_strobe,
	input logic control_rd,
	input logic control_write,
	output lb_data_t data_in
);

	localparam int n_words = 2 ** bank_addr_bits;

	lb_data_t mem [n_words];
	lb_data_t rd_pipe [read_pipe_len];
	lb_data_t rd_word;
	logic [bank_addr_bits-1:0] word_idx;
	logic in_range;
	logic rd_strobe;

	// only addresses with every bit above the bank index clear decode
	assign word_idx = addr[bank_addr_bits-1:0];
	assign in_range = (addr[$bits(lb_addr_t)-1:bank_addr_bits] == '0);
	assign rd_strobe = control_strobe && control_rd;
	assign rd_word = in_range ? mem[word_idx] : '0;

	// the write lands on the same edge as control_write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < n_words; i++) begin
				mem[i] <= '0;
			end
		end else if (control_write && in_range) begin
			mem[word_idx] <= data_out;
		end
	end

	// stage 0 captures the word at the strobe and the rest just shift
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < read_pipe_len; k++) begin
				rd_pipe[k] <= '0;
			end
		end else begin
			if (rd_strobe) begin
				rd_pipe[0] <= rd_word;
			end
			for (int k = 1; k < read_pipe_len; k++) begin
				rd_pipe[k] <= rd_pipe[k-1];
			end
		end
	end

	assign data_in = rd_pipe[read_pipe_len-1];

	// the gateway never marks one operation as both a write and a read
	a_no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(control_write && rd_strobe));

endmodule

// File: rtl/mem_gateway.sv
`timescale 1ns/1ps

// maps the payload of a UDP packet onto the local register bus
// the payload starts with pad_bytes of padding that is echoed untouched
// after it 32-bit command words and 32-bit data words alternate in big-endian order
// the whole packet is returned on odata n_lat cycles later with the data
// words of read operations replaced by what the bus returned
module mem_gateway
	import mem_gate_pkg::*;
#(
	// bus read latency of at least 1 cycle
	parameter int read_pipe_len = 3,
	// end-to-end byte latency of at least 5 + read_pipe_len cycles
	parameter int n_lat = 8,
	parameter bit enable_bursts = 1'b0
) (
	input logic clk,
	input logic rst_n,
	// payload length as reported by the packet engine
	input logic [10:0] len_c,
	input byte_t idata,
	input logic raw_l,
	input logic raw_s,
	output byte_t odata,
	output lb_addr_t addr,
	output logic control_strobe,
	output logic control_rd,
	output logic control_write,
	output logic control_rd_valid,
	output logic control_prefill,
	output logic [read_pipe_len:0] control_pipe_rd,
	output lb_data_t data_out,
	input lb_data_t data_in
);

	// the byte counter also covers the padding and its low two bits index a byte in a word
	localparam int pad_cnt_w = $clog2(pad_bytes);
	localparam logic [pad_cnt_w-1:0] pad_last = pad_cnt_w'(pad_bytes - 1);

	byte_t pdata;
	byte_t xdata;
	logic [pad_cnt_w-1:0] byte_cnt;
	parse_state_t state;
	logic [23:0] isr;
	lb_data_t next_word;
	lb_data_t cmd_r;
	lb_data_t data_r;
	rep_count_t repeat_count;
	logic inc_address;
	logic do_op;
	logic word_done;
	logic set_repeat;
	logic read_op;
	logic [read_pipe_len-1:0] read_markers;
	lb_data_t osr;
	logic raw_l_r;
	logic prefill_r;

	// input bytes wait here until a read result can be spliced in
	reg_delay #(
		.len(read_pipe_len + 1),
		.dw($bits(byte_t))
	) i_align (
		.clk(clk),
		.rst_n(rst_n),
		.din(idata),
		.dout(pdata)
	);

	// the current byte completes a 32-bit word on the last byte of each group of four
	assign next_word = {isr, idata};
	assign word_done = raw_s && (byte_cnt[1:0] == 2'b11);
	assign set_repeat = enable_bursts && next_word[ctl_repeat_bit];

	// parser state, repeat counter and the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			state <= st_pad;
			repeat_count <= '0;
			inc_address <= 1'b0;
			do_op <= 1'b0;
		end else begin
			byte_cnt <= raw_s ? byte_cnt + 1'b1 : '0;
			do_op <= word_done && (state == st_data);
			if (!raw_s) begin
				// a gap in raw_s ends the packet and rearms the parser
				state <= st_pad;
				repeat_count <= '0;
				inc_address <= 1'b0;
			end else if (word_done) begin
				inc_address <= 1'b0;
				case (state)
					st_pad: begin
						if (byte_cnt == pad_last) begin
							state <= st_cmd;
						end
					end
					st_cmd: begin
						// a repeat command is consumed here and the real command follows
						if (set_repeat) begin
							repeat_count <= next_word[$bits(rep_count_t)-1:0] - 1'b1;
						end else begin
							state <= st_data;
						end
					end
					st_data: begin
						// stay in the data phase while repetitions are left
						if (|repeat_count) begin
							repeat_count <= repeat_count - 1'b1;
							inc_address <= 1'b1;
						end else begin
							state <= st_cmd;
						end
					end
					default: state <= st_pad;
				endcase
			end
		end
	end

	// word assembly and the command and data holding registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			isr <= '0;
			cmd_r <= '0;
			data_r <= '0;
		end else begin
			isr <= next_word[23:0];
			if (word_done && state == st_cmd && !set_repeat) begin
				cmd_r <= next_word;
			end
			if (word_done && state == st_data) begin
				data_r <= next_word;
				// only the address field steps while the control bits stay put
				if (inc_address) begin
					cmd_r[$bits(lb_addr_t)-1:0] <= cmd_r[$bits(lb_addr_t)-1:0] + 1'b1;
				end
			end
		end
	end

	// addr, data_out and control_rd are levels that move when a data word completes
	assign addr = cmd_r[$bits(lb_addr_t)-1:0];
	assign control_rd = cmd_r[ctl_read_bit];
	assign data_out = data_r;
	assign control_strobe = do_op;
	assign control_write = do_op && !control_rd;

	// bit k of control_pipe_rd marks a read issued k cycles ago
	assign read_op = control_strobe && control_rd;
	assign control_pipe_rd = {read_markers, read_op};
	assign control_rd_valid = control_pipe_rd[read_pipe_len];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_markers <= '0;
		end else begin
			read_markers <= control_pipe_rd[read_pipe_len-1:0];
		end
	end

	// in the output shifter the read word lands exactly over its own data bytes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			osr <= '0;
		end else if (control_rd_valid) begin
			osr <= data_in;
		end else begin
			osr <= {osr[23:0], pdata};
		end
	end

	assign xdata = osr[31:24];

	// whatever latency is left over after alignment and the shifter
	reg_delay #(
		.len(n_lat - read_pipe_len - 5),
		.dw($bits(byte_t))
	) i_finale (
		.clk(clk),
		.rst_n(rst_n),
		.din(xdata),
		.dout(odata)
	);

	// the leading edge of raw_l gives a one-cycle pulse two edges after raw_l rises
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raw_l_r <= 1'b0;
			prefill_r <= 1'b0;
		end else begin
			raw_l_r <= raw_l;
			prefill_r <= raw_l && !raw_l_r;
		end
	end

	assign control_prefill = prefill_r;

	// bus operations come at most once per four cycles
	a_strobe_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		control_strobe |=> !control_strobe [*3]);

	// every captured word belongs to a read data word that completed read_pipe_len + 1 cycles before
	a_rd_valid_source: assert property (@(posedge clk) disable iff (!rst_n)
		control_rd_valid |-> $past(word_done && state == st_data && cmd_r[ctl_read_bit],
			read_pipe_len + 1));

endmodule

// File: rtl/mem_gate_top.sv
`timescale 1ns/1ps

// packet-to-register gateway together with its register bank
// the packet engine side is left open for the testbench to drive
module mem_gate_top
	import mem_gate_pkg::*;
#(
	parameter int read_pipe_len = 3,
	parameter int n_lat = 8,
	parameter bit enable_bursts = 1'b1,
	parameter int bank_addr_bits = 4
) (
	input logic clk,
	input logic rst_n,
	input logic [10:0] len_c,
	input byte_t idata,
	input logic raw_l,
	input logic raw_s,
	output byte_t odata,
	output logic control_prefill
);

	// local bus between gateway and bank
	lb_addr_t addr;
	lb_data_t data_out;
	lb_data_t data_in;
	logic control_strobe;
	logic control_rd;
	logic control_write;

	mem_gateway #(
		.read_pipe_len(read_pipe_len),
		.n_lat(n_lat),
		.enable_bursts(enable_bursts)
	) i_mem_gateway (
		.clk(clk),
		.rst_n(rst_n),
		.len_c(len_c),
		.idata(idata),
		.raw_l(raw_l),
		.raw_s(raw_s),
		.odata(odata),
		.addr(addr),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.control_write(control_write),
		// the bank keeps its own read pipeline, so these are not needed here
		.control_rd_valid(),
		.control_prefill(control_prefill),
		.control_pipe_rd(),
		.data_out(data_out),
		.data_in(data_in)
	);

	reg_bank #(
		.read_pipe_len(read_pipe_len),
		.bank_addr_bits(bank_addr_bits)
	) i_reg_bank (
		.clk(clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_out(data_out),
		.control_strobe(control_strobe),
		.control_rd(control_rd),
		.control_write(control_write),
		.data_in(data_in)
	);

endmodule

// File: test/tb_mem_gate.sv
`timescale 1ns/1ps

// directed testbench for the UDP payload to register bus gateway
// packets are built as byte queues together with the reply they should produce
module tb_mem_gate
	import mem_gate_pkg::*;
();

	// end-to-end byte latency as set by default in the top level
	localparam int n_lat = 8;
	// about ten times the length of all tests together
	localparam int timeout_cycles = 3000;

	logic clk;
	logic rst_n;
	logic [10:0] len_c;
	byte_t idata;
	logic raw_l;
	logic raw_s;
	byte_t odata;
	logic control_prefill;

	// bytes sent, bytes expected back and bytes collected from odata
	byte_t tx_q[$];
	byte_t exp_q[$];
	byte_t rx_q[$];

	// reference copy of the 16 bank words that is updated in packet order
	lb_data_t model [16];

	int pass_count;
	int fail_count;
	int cycle_count = 0;
	int unsigned seed_val;

	mem_gate_top #(
		.enable_bursts(1'b1)
	) i_mem_gate_top (
		.clk(clk),
		.rst_n(rst_n),
		.len_c(len_c),
		.idata(idata),
		.raw_l(raw_l),
		.raw_s(raw_s),
		.odata(odata),
		.control_prefill(control_prefill)
	);

	always #2 clk = ~clk;

	// stops a run that never reaches the end of the test sequence
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run timed out after %0d cycles before the tests completed", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check(input logic [31:0] expected, input logic [31:0] actual,
			input string msg);
		if (expected !== actual) begin
			fail_count++;
			$display("error at %0t ns: %s, expected %h, got %h", $time, msg, expected, actual);
		end else begin
			pass_count++;
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %s done, %0d failed checks", name, fail_count - fails_before);
	endtask

	// the bank decodes 4 index bits and wants every higher address bit clear
	function automatic lb_data_t model_read(input lb_addr_t a);
		if (a[23:4] != '0) begin
			return '0;
		end
		return model[a[3:0]];
	endfunction

	// a word goes out big-endian and the reply may carry a different word
	task automatic push_word(input lb_data_t sent, input lb_data_t reply);
		for (int i = 3; i >= 0; i--) begin
			tx_q.push_back(sent[8*i +: 8]);
			exp_q.push_back(reply[8*i +: 8]);
		end
	endtask

	// random padding is echoed as it is
	task automatic start_packet();
		tx_q.delete();
		exp_q.delete();
		for (int i = 0; i < pad_bytes; i++) begin
			tx_q.push_back(byte_t'($urandom));
			exp_q.push_back(tx_q[i]);
		end
	endtask

	// one operation or a burst of n with a repeat command in front when n is above 1
	task automatic add_op(input bit rd, input lb_addr_t base, input int n);
		lb_data_t cmd;
		lb_data_t wdata;
		lb_addr_t a;
		if (n > 1) begin
			cmd = '0;
			cmd[ctl_repeat_bit] = 1'b1;
			cmd[$bits(rep_count_t)-1:0] = rep_count_t'(n);
			push_word(cmd, cmd);
		end
		cmd = lb_data_t'(base);
		cmd[ctl_read_bit] = rd;
		push_word(cmd, cmd);
		for (int i = 0; i < n; i++) begin
			a = base + lb_addr_t'(i);
			wdata = $urandom;
			if (rd) begin
				// a read reply carries the bank word as it is at this point of the packet
				push_word(wdata, model_read(a));
			end else begin
				push_word(wdata, wdata);
				if (a[23:4] == '0) begin
					model[a[3:0]] = wdata;
				end
			end
		end
	endtask

	// streams tx_q and collects as many bytes from odata in parallel
	task automatic send_packet();
		rx_q.delete();
		fork
			begin
				foreach (tx_q[i]) begin
					@(posedge clk);
					#1;
					idata = tx_q[i];
					raw_s = 1'b1;
					raw_l = 1'b1;
					len_c = 11'(tx_q.size());
				end
				// one idle cycle ends the packet and rearms the parser
				@(posedge clk);
				#1;
				idata = '0;
				raw_s = 1'b0;
				raw_l = 1'b0;
			end
			begin
				// a byte driven after an edge is taken on the next one
				// and is then stable on odata n_lat edges later
				repeat (n_lat + 1) @(posedge clk);
				foreach (tx_q[i]) begin
					@(negedge clk);
					rx_q.push_back(odata);
				end
			end
		join
	endtask

	task automatic compare_reply(input string name);
		foreach (exp_q[i]) begin
			check(exp_q[i], rx_q[i], $sformatf("%s reply byte %0d", name, i));
		end
	endtask

	task automatic test_reset();
		int fails_before;
		fails_before = fail_count;
		repeat (6) begin
			@(negedge clk);
			check(0, odata, "odata after reset");
			check(0, control_prefill, "control_prefill after reset");
		end
		report_test("reset", fails_before);
	endtask

	task automatic test_echo();
		int fails_before;
		fails_before = fail_count;
		start_packet();
		add_op(1'b0, 24'h000001, 1);
		add_op(1'b0, 24'h000002, 1);
		add_op(1'b0, 24'h000003, 1);
		send_packet();
		compare_reply("echo");
		report_test("echo", fails_before);
	endtask

	task automatic test_write_read();
		int fails_before;
		fails_before = fail_count;
		start_packet();
		add_op(1'b0, 24'h000000, 1);
		add_op(1'b0, 24'h000004, 1);
		add_op(1'b0, 24'h000005, 1);
		add_op(1'b0, 24'h00000f, 1);
		// read back out of order, word 1 still holds what the echo test wrote
		add_op(1'b1, 24'h00000f, 1);
		add_op(1'b1, 24'h000005, 1);
		add_op(1'b1, 24'h000000, 1);
		add_op(1'b1, 24'h000004, 1);
		add_op(1'b1, 24'h000001, 1);
		send_packet();
		compare_reply("write_read");
		report_test("write_read", fails_before);
	endtask

	task automatic test_out_of_range();
		int fails_before;
		fails_before = fail_count;
		start_packet();
		// 0x100 shares its low index bits with word 0 and must not touch it
		add_op(1'b0, 24'h000100, 1);
		add_op(1'b0, 24'h800003, 1);
		add_op(1'b1, 24'h000100, 1);
		add_op(1'b1, 24'h000000, 1);
		add_op(1'b1, 24'h000003, 1);
		send_packet();
		compare_reply("out_of_range");
		report_test("out_of_range", fails_before);
	endtask

	task automatic test_bursts();
		int fails_before;
		fails_before = fail_count;
		start_packet();
		add_op(1'b0, 24'h000008, 4);
		add_op(1'b1, 24'h000008, 4);
		send_packet();
		compare_reply("bursts");
		report_test("bursts", fails_before);
	endtask

	task automatic test_prefill();
		int fails_before;
		fails_before = fail_count;
		@(posedge clk);
		#1;
		raw_l = 1'b1;
		// the pulse follows the second edge when the launch edge is counted and lasts one cycle
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			check(k == 1, control_prefill, $sformatf("control_prefill in cycle %0d", k));
		end
		@(posedge clk);
		#1;
		raw_l = 1'b0;
		report_test("prefill", fails_before);
	endtask

	initial begin
		seed_val = $urandom(50864);
		clk = 1'b0;
		rst_n = 1'b0;
		len_c = '0;
		idata = '0;
		raw_l = 1'b0;
		raw_s = 1'b0;
		pass_count = 0;
		fail_count = 0;
		foreach (model[i]) begin
			model[i] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_echo();
		test_write_read();
		test_out_of_range();
		test_bursts();
		test_prefill();
		$display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: mem_gate.f
rtl/mem_gate_pkg.sv
rtl/reg_delay.sv
rtl/reg_bank.sv
rtl/mem_gateway.sv
rtl/mem_gate_top.sv
test/tb_mem_gate.sv
